/* sources.f */
src/bg_pkg.sv
src/vga_timing_if.sv
src/platform_painter.sv
src/scenery_painter.sv
src/house_painter.sv
src/bg_compositor.sv
src/draw_bg.sv
verif/tb_draw_bg.sv

/* verif/draw_bg_stim.txt */
// hcount vcount (decimal)  hsync vsync hblnk vblnk (binary)  expected rgb (hex)
// timing outputs must repeat the inputs one cycle later
1030 10 0 0 1 0 000
500 770 0 1 0 1 000
1100 800 1 1 1 1 000
300 200 1 0 1 0 000
0 0 0 0 1 0 000
0 0 0 0 0 0 ff0
1023 767 0 1 0 0 f00
512 0 1 0 0 0 ff0
512 767 0 0 0 0 f00
0 384 0 0 0 0 0f0
1023 384 1 1 0 0 00f
200 460 0 0 0 0 111
950 310 1 0 0 0 111
402 380 0 0 0 0 000
601 379 0 0 0 0 000
602 378 0 1 0 0 000
403 378 0 0 0 0 852
250 470 0 0 0 0 852
900 460 0 0 0 0 ccc
551 180 0 0 0 0 0af
700 180 1 0 0 0 000
752 178 0 0 0 0 000
401 249 0 0 0 0 000
402 249 0 0 0 0 0af
300 550 0 0 0 0 000
600 700 1 1 0 0 0b0
1000 551 0 0 0 0 0b0
200 350 0 0 0 0 000
500 420 0 0 0 0 000
1 420 0 0 0 0 000
150 549 0 0 0 0 000
150 420 1 0 0 0 852
550 500 0 0 0 0 0af
150 290 0 0 0 0 0af
700 260 0 0 0 0 a10
650 400 0 0 0 0 000
700 300 0 1 0 0 000
735 360 0 0 0 0 ddf
765 360 0 0 0 0 000
735 390 0 0 0 0 000
950 500 1 0 0 0 741
910 400 0 0 0 0 000
915 451 0 0 0 0 eee
925 449 0 0 0 0 eee
925 451 0 0 0 0 741
880 500 0 0 0 0 ccc
800 240 0 0 0 0 0af

/* verif/tb_draw_bg.sv */
`timescale 1ns/1ps

module tb_draw_bg;
    import bg_pkg::*;

    localparam int  max_lines  = 1000;  // bound on the file loop
    localparam time clk_period = 40;

    logic   clk;
    logic   rst;
    count_t hcount_in;
    count_t vcount_in;
    logic   hsync_in;
    logic   vsync_in;
    logic   hblnk_in;
    logic   vblnk_in;
    count_t hcount_out;
    count_t vcount_out;
    logic   hsync_out;
    logic   vsync_out;
    logic   hblnk_out;
    logic   vblnk_out;
    rgb_t   rgb_out;

    int    err_value;
    int    err_other;
    int    pixels;
    int    lines;
    int    fd;
    int    status;
    int    hc;
    int    vc;
    int    hs;
    int    vs;
    int    hb;
    int    vb;
    int    exp_rgb;
    int    prev [7];  // last checked pixel
    string line;

    draw_bg i_draw_bg (
        .clk        (clk),
        .rst        (rst),
        .hcount_in  (hcount_in),
        .vcount_in  (vcount_in),
        .hsync_in   (hsync_in),
        .vsync_in   (vsync_in),
        .hblnk_in   (hblnk_in),
        .vblnk_in   (vblnk_in),
        .hcount_out (hcount_out),
        .vcount_out (vcount_out),
        .hsync_out  (hsync_out),
        .vsync_out  (vsync_out),
        .hblnk_out  (hblnk_out),
        .vblnk_out  (vblnk_out),
        .rgb_out    (rgb_out)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [11:0] expected,
                                   input logic [11:0] actual);
        $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        err_value++;
    endtask

    // compare all outputs with one expected pixel
    task automatic check_outputs(input int e_hc, input int e_vc, input int e_hs,
                                 input int e_vs, input int e_hb, input int e_vb,
                                 input int e_rgb);
        if (rgb_out !== rgb_t'(e_rgb))
            report_mismatch("rgb_out", e_rgb, rgb_out);
        if (hcount_out !== count_t'(e_hc))
            report_mismatch("hcount_out", e_hc, hcount_out);
        if (vcount_out !== count_t'(e_vc))
            report_mismatch("vcount_out", e_vc, vcount_out);
        if (hsync_out !== e_hs[0])
            report_mismatch("hsync_out", e_hs, hsync_out);
        if (vsync_out !== e_vs[0])
            report_mismatch("vsync_out", e_vs, vsync_out);
        if (hblnk_out !== e_hb[0])
            report_mismatch("hblnk_out", e_hb, hblnk_out);
        if (vblnk_out !== e_vb[0])
            report_mismatch("vblnk_out", e_vb, vblnk_out);
    endtask

    task automatic drive_pixel(input int d_hc, input int d_vc, input int d_hs,
                               input int d_vs, input int d_hb, input int d_vb);
        @(negedge clk);
        hcount_in = count_t'(d_hc);
        vcount_in = count_t'(d_vc);
        hsync_in  = d_hs[0];
        vsync_in  = d_vs[0];
        hblnk_in  = d_hb[0];
        vblnk_in  = d_vb[0];
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        err_value = 0;
        err_other = 0;
        pixels    = 0;
        rst       = 1'b1;
        hcount_in = '0;
        vcount_in = '0;
        hsync_in  = 1'b0;
        vsync_in  = 1'b0;
        hblnk_in  = 1'b0;
        vblnk_in  = 1'b0;

        // busy inputs during reset but outputs stay cleared
        for (int c = 0; c < 8; c++) begin
            @(posedge clk);
            #(clk_period / 4);
            check_outputs(0, 0, 0, 0, 0, 0, 0);
            if (c < 7)
                drive_pixel(c * 100 + 7, c * 50 + 3, 1, 1, 1, 1);
        end
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("verif/draw_bg_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verif/draw_bg_stim.txt");
            err_other++;
        end else begin
            lines = 0;
            while (!$feof(fd) && lines < max_lines) begin
                line   = "";
                status = $fgets(line, fd);
                lines++;
                if (line.len() == 0 || line[0] == "/" || line[0] == "\n")
                    continue;  // comments and blank lines
                status = $sscanf(line, "%d %d %b %b %b %b %h", hc, vc, hs, vs, hb, vb, exp_rgb);
                if (status != 7) begin
                    $display("stimulus line %0d could not be parsed", lines);
                    err_other++;
                end else begin
                    drive_pixel(hc, vc, hs, vs, hb, vb);
                    #(clk_period / 4);
                    if (pixels > 0)  // older pixel held until the next edge
                        check_outputs(prev[0], prev[1], prev[2], prev[3], prev[4], prev[5],
                                      prev[6]);
                    @(posedge clk);
                    #(clk_period / 4);
                    check_outputs(hc, vc, hs, vs, hb, vb, exp_rgb);
                    prev = '{hc, vc, hs, vs, hb, vb, exp_rgb};
                    pixels++;
                end
            end
            if (!$feof(fd)) begin
                $display("stimulus file longer than %0d lines, reading stopped", max_lines);
                err_other++;
            end
            $fclose(fd);
            if (pixels == 0) begin
                $display("the stimulus file holds no pixels");
                err_other++;
            end
        end

        $display("done: %0d pixels, %0d value errors, %0d other errors",
                 pixels, err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* src/draw_bg.sv */
`timescale 1ns/1ps

module draw_bg (
    input  logic           clk,
    input  logic           rst,
    input  bg_pkg::count_t hcount_in,
    input  bg_pkg::count_t vcount_in,
    input  logic           hsync_in,
    input  logic           vsync_in,
    input  logic           hblnk_in,
    input  logic           vblnk_in,
    output bg_pkg::count_t hcount_out,
    output bg_pkg::count_t vcount_out,
    output logic           hsync_out,
    output logic           vsync_out,
    output logic           hblnk_out,
    output logic           vblnk_out,
    output bg_pkg::rgb_t   rgb_out
);
    import bg_pkg::*;

    logic plat_hit;
    logic scen_hit;
    logic house_hit;
    rgb_t plat_rgb;
    rgb_t scen_rgb;
    rgb_t house_rgb;

    vga_timing_if pix_in ();

    assign pix_in.hcount = hcount_in;
    assign pix_in.vcount = vcount_in;
    assign pix_in.hsync  = hsync_in;
    assign pix_in.vsync  = vsync_in;
    assign pix_in.hblnk  = hblnk_in;
    assign pix_in.vblnk  = vblnk_in;

    platform_painter i_platform_painter (.pix(pix_in), .hit(plat_hit), .rgb(plat_rgb));

    scenery_painter i_scenery_painter (.pix(pix_in), .hit(scen_hit), .rgb(scen_rgb));

    house_painter i_house_painter (.pix(pix_in), .hit(house_hit), .rgb(house_rgb));

    bg_compositor i_bg_compositor (
        .clk        (clk),
        .rst        (rst),
        .pix        (pix_in),
        .plat_hit   (plat_hit),
        .plat_rgb   (plat_rgb),
        .scen_hit   (scen_hit),
        .scen_rgb   (scen_rgb),
        .house_hit  (house_hit),
        .house_rgb  (house_rgb),
        .hcount_out (hcount_out),
        .vcount_out (vcount_out),
        .hsync_out  (hsync_out),
        .vsync_out  (vsync_out),
        .hblnk_out  (hblnk_out),
        .vblnk_out  (vblnk_out),
        .rgb_out    (rgb_out)
    );

endmodule

/* src/bg_compositor.sv */
`timescale 1ns/1ps

module bg_compositor (
    input  logic              clk,
    input  logic              rst,
    vga_timing_if.compositor  pix,
    input  logic              plat_hit,
    input  bg_pkg::rgb_t      plat_rgb,
    input  logic              scen_hit,
    input  bg_pkg::rgb_t      scen_rgb,
    input  logic              house_hit,
    input  bg_pkg::rgb_t      house_rgb,
    output bg_pkg::count_t    hcount_out,
    output bg_pkg::count_t    vcount_out,
    output logic              hsync_out,
    output logic              vsync_out,
    output logic              hblnk_out,
    output logic              vblnk_out,
    output bg_pkg::rgb_t      rgb_out
);
    import bg_pkg::*;

    layer_e layer;
    rgb_t   border_rgb;
    logic   on_border;
    rgb_t   rgb_nxt;

    // border sides, top and bottom take the corners
    always_comb begin
        on_border  = 1'b1;
        border_rgb = color_black;
        if (pix.vcount == '0) begin
            border_rgb = color_yellow;
        end else if (pix.vcount == ver_pixels - 11'd1) begin
            border_rgb = color_red;
        end else if (pix.hcount == '0) begin
            border_rgb = color_green;
        end else if (pix.hcount == hor_pixels - 11'd1) begin
            border_rgb = color_blue;
        end else begin
            on_border = 1'b0;
        end
    end

    always_comb begin
        if (pix.hblnk || pix.vblnk) begin
            layer = layer_blank;
        end else if (on_border) begin
            layer = layer_border;
        end else if (plat_hit) begin
            layer = layer_platform;
        end else if (scen_hit) begin
            layer = layer_scenery;
        end else if (house_hit) begin
            layer = layer_house;
        end else begin
            layer = layer_sky;
        end
    end

    always_comb begin
        case (layer)
            layer_blank:    rgb_nxt = color_black;
            layer_border:   rgb_nxt = border_rgb;
            layer_platform: rgb_nxt = plat_rgb;
            layer_scenery:  rgb_nxt = scen_rgb;
            layer_house:    rgb_nxt = house_rgb;
            default:        rgb_nxt = color_sky;
        endcase
    end

    // one pixel of delay for colour and timing alike
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hblnk_out  <= 1'b0;
            vblnk_out  <= 1'b0;
            rgb_out    <= '0;
        end else begin
            hcount_out <= pix.hcount;
            vcount_out <= pix.vcount;
            hsync_out  <= pix.hsync;
            vsync_out  <= pix.vsync;
            hblnk_out  <= pix.hblnk;
            vblnk_out  <= pix.vblnk;
            rgb_out    <= rgb_nxt;
        end
    end

endmodule

/* src/house_painter.sv */
`timescale 1ns/1ps

module house_painter (
    vga_timing_if.painter pix,
    output logic          hit,
    output bg_pkg::rgb_t  rgb
);
    import bg_pkg::*;

    logic in_window;
    logic window_line;
    logic in_door;
    logic on_handle;

    assign hit = (pix.vcount >= house_top) && (pix.vcount <= house_bottom) &&
                 (pix.hcount >= house_left) && (pix.hcount <= hor_pixels - 11'd1);

    assign in_window = (pix.hcount >= window_left) && (pix.hcount <= window_right) &&
                       (pix.vcount >= window_top) && (pix.vcount <= window_bottom);

    // frame plus the cross bars
    assign window_line = (pix.hcount == window_left) || (pix.hcount == window_right) ||
                         (pix.vcount == window_top) || (pix.vcount == window_bottom) ||
                         (pix.hcount == window_bar_x) || (pix.vcount == window_bar_y);

    assign in_door = (pix.hcount >= door_left) && (pix.vcount >= door_top) &&
                     (pix.vcount < house_bottom);

    // short stem and a bar going right
    assign on_handle = ((pix.vcount >= handle_top) && (pix.vcount <= handle_bottom) &&
                        (pix.hcount == handle_x)) ||
                       ((pix.vcount >= handle_top) && (pix.vcount <= handle_bar_bottom) &&
                        (pix.hcount >= handle_x) && (pix.hcount <= handle_bar_right));

    always_comb begin
        if (pix.vcount < house_roof_bottom) begin
            rgb = color_roof;
        end else if ((pix.hcount == house_left) || (pix.vcount == house_roof_bottom)) begin
            rgb = color_black;  // outline
        end else if (in_window) begin
            rgb = window_line ? color_black : color_glass;
        end else if (in_door) begin
            if ((pix.hcount == door_left) || (pix.vcount == door_top)) begin
                rgb = color_black;
            end else if (on_handle) begin
                rgb = color_handle;
            end else begin
                rgb = color_door;
            end
        end else begin
            rgb = color_wall;
        end
    end

endmodule

/* src/scenery_painter.sv */
`timescale 1ns/1ps

module scenery_painter (
    vga_timing_if.painter pix,
    output logic          hit,
    output bg_pkg::rgb_t  rgb
);
    import bg_pkg::*;

    logic in_grass;
    logic in_fence;
    logic fence_line;

    assign in_grass = (pix.vcount >= grass_top) &&
                      (pix.vcount <= ver_pixels - 11'd1) &&
                      (pix.hcount != '0) &&
                      (pix.hcount <= hor_pixels - 11'd1);

    assign in_fence = (pix.vcount >= fence_top) &&
                      (pix.vcount < grass_top) &&
                      (pix.hcount >= fence_left) &&
                      (pix.hcount <= fence_right);

    // end posts, inner posts and the base line
    assign fence_line = (pix.hcount == fence_left) ||
                        (pix.hcount == fence_right) ||
                        ((pix.hcount % fence_post_step) == '0) ||
                        (pix.vcount == grass_top - 11'd1);

    always_comb begin
        hit = 1'b0;
        rgb = color_black;
        if (in_grass) begin
            hit = 1'b1;
            if (pix.vcount == grass_top) begin
                rgb = color_black;  // outline on top of the grass
            end else begin
                rgb = color_grass;
            end
        end else if (in_fence) begin
            hit = 1'b1;
            if (fence_line) begin
                rgb = color_black;
            end else begin
                rgb = color_wood;
            end
        end
    end

endmodule

/* src/platform_painter.sv */
`timescale 1ns/1ps

module platform_painter (
    vga_timing_if.painter pix,
    output logic          hit,
    output bg_pkg::rgb_t  rgb
);
    import bg_pkg::*;

    logic body_hit;
    logic bevel_hit;

    // strictly inside any rectangle
    always_comb begin
        body_hit = 1'b0;
        for (int i = 0; i < num_platforms; i++) begin
            if ((pix.hcount > platforms[i].x_start) &&
                (pix.hcount < platforms[i].x_end) &&
                (pix.vcount > platforms[i].y_start) &&
                (pix.vcount < platforms[i].y_end)) begin
                body_hit = 1'b1;
            end
        end
    end

    // three rows on top, each shifted one pixel further right
    always_comb begin
        bevel_hit = 1'b0;
        for (int i = 0; i < num_platforms; i++) begin
            for (int k = 0; k < 3; k++) begin
                if ((pix.vcount == platforms[i].y_start - k) &&
                    (pix.hcount > platforms[i].x_start + k + 1) &&
                    (pix.hcount < platforms[i].x_end + k + 1)) begin
                    bevel_hit = 1'b1;
                end
            end
        end
    end

    always_comb begin
        hit = body_hit || bevel_hit;
        if (body_hit) begin
            rgb = color_platform;  // body beats another platform's bevel
        end else begin
            rgb = color_black;
        end
    end

endmodule

/* src/vga_timing_if.sv */
`timescale 1ns/1ps

interface vga_timing_if;
    import bg_pkg::*;

    count_t hcount;
    count_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;

    modport compositor (
        input hcount,
        input vcount,
        input hsync,
        input vsync,
        input hblnk,
        input vblnk
    );

    // painters only need the position
    modport painter (
        input hcount,
        input vcount
    );

endinterface

/* src/bg_pkg.sv */
package bg_pkg;

    // visible screen
    localparam logic [10:0] hor_pixels = 11'd1024;
    localparam logic [10:0] ver_pixels = 11'd768;

    typedef logic [10:0] count_t;
    typedef logic [11:0] rgb_t;     // 4 bits each, r g b

    localparam rgb_t color_black    = 12'h0_0_0;
    localparam rgb_t color_yellow   = 12'hf_f_0;
    localparam rgb_t color_red      = 12'hf_0_0;
    localparam rgb_t color_green    = 12'h0_f_0;
    localparam rgb_t color_blue     = 12'h0_0_f;
    localparam rgb_t color_platform = 12'h1_1_1;
    localparam rgb_t color_grass    = 12'h0_b_0;
    localparam rgb_t color_wood     = 12'h8_5_2;
    localparam rgb_t color_roof     = 12'ha_1_0;
    localparam rgb_t color_wall     = 12'hc_c_c;
    localparam rgb_t color_glass    = 12'hd_d_f;
    localparam rgb_t color_door     = 12'h7_4_1;
    localparam rgb_t color_handle   = 12'he_e_e;
    localparam rgb_t color_sky      = 12'h0_a_f;

    typedef struct packed {
        count_t x_start;
        count_t x_end;
        count_t y_start;
        count_t y_end;
    } plat_rect_t;

    localparam int num_platforms = 6;

    localparam plat_rect_t platforms [num_platforms] = '{
        '{x_start: 11'd100, x_end: 11'd300,  y_start: 11'd450, y_end: 11'd470},
        '{x_start: 11'd400, x_end: 11'd600,  y_start: 11'd380, y_end: 11'd400},
        '{x_start: 11'd700, x_end: 11'd900,  y_start: 11'd450, y_end: 11'd470},
        '{x_start: 11'd200, x_end: 11'd400,  y_start: 11'd250, y_end: 11'd270},
        '{x_start: 11'd550, x_end: 11'd750,  y_start: 11'd180, y_end: 11'd200},
        '{x_start: 11'd800, x_end: 11'd1000, y_start: 11'd300, y_end: 11'd320}
    };

    // ground and fence
    localparam count_t grass_top       = 11'd550;
    localparam count_t fence_top       = 11'd300;
    localparam count_t fence_left      = 11'd1;
    localparam count_t fence_right     = 11'd500;
    localparam count_t fence_post_step = 11'd100;

    // house body
    localparam count_t house_left        = 11'd650;
    localparam count_t house_top         = 11'd250;
    localparam count_t house_roof_bottom = 11'd300;
    localparam count_t house_bottom      = 11'd550;

    localparam count_t window_left   = 11'd705;
    localparam count_t window_right  = 11'd825;
    localparam count_t window_top    = 11'd330;
    localparam count_t window_bottom = 11'd450;
    localparam count_t window_bar_x  = 11'd765;
    localparam count_t window_bar_y  = 11'd390;

    localparam count_t door_left         = 11'd910;
    localparam count_t door_top          = 11'd350;
    localparam count_t handle_top        = 11'd448;
    localparam count_t handle_bottom     = 11'd451;
    localparam count_t handle_x          = 11'd915;
    localparam count_t handle_bar_bottom = 11'd449;
    localparam count_t handle_bar_right  = 11'd925;

    // highest priority first
    typedef enum logic [2:0] {
        layer_blank,
        layer_border,
        layer_platform,
        layer_scenery,
        layer_house,
        layer_sky
    } layer_e;

endpackage
